// File: core_consts.svh
// widths, depths and reset PC shared by the RTL and the testbench
// XLEN must stay 32, decode and the ALU assume RV32 fields
// fetch-buffer depth must be a power of two, 2 or more

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data and PC width
`define CORE_XLEN 32

// architectural register index width
`define CORE_REG_INDEX_SIZE 5

// integer register count, x0 reads as zero
`define CORE_NUM_REGS 32

// default fetch-buffer entries
`define CORE_FB_DEPTH 4

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: core_pkg.sv
// micro-op types for the single-issue integer core
// OP_NOP covers every unsupported encoding and still retires

`include "core_consts.svh"

package core_pkg;

  // supported operations
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SLT,
    OP_ADDI,
    OP_LUI,
    OP_NOP
  } opcode_t;

  // decoded instruction as it travels through the buffer and the pipe
  typedef struct packed {
    logic [`CORE_XLEN-1:0]           pc;
    opcode_t                         op;
    logic [`CORE_REG_INDEX_SIZE-1:0] rs1;
    logic                            rs1_used;
    logic [`CORE_REG_INDEX_SIZE-1:0] rs2;
    logic                            rs2_used;
    logic [`CORE_REG_INDEX_SIZE-1:0] rd;
    // low for x0 and for no-ops
    logic                            rd_write;
    // already sign-extended or shifted
    logic [`CORE_XLEN-1:0]           imm;
  } micro_op_t;

endpackage

// File: inst_decode.sv
// RV32 decoder for ADD/SUB/AND/OR/XOR/SLL/SRL/SLT, ADDI and LUI
// anything else becomes OP_NOP with no sources and no write
// unused register fields are forced to zero

`timescale 1ns/1ps

`include "core_consts.svh"

module inst_decode (
  input  logic [`CORE_XLEN-1:0] inst,
  input  logic [`CORE_XLEN-1:0] pc,
  output core_pkg::micro_op_t   uop
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  always_comb begin
    uop          = '0;
    uop.pc       = pc;
    uop.op       = core_pkg::OP_NOP;
    uop.rs1_used = 1'b0;
    uop.rs2_used = 1'b0;

    case (opcode)
      // register-register ALU
      7'b0110011: begin
        uop.rs1_used = 1'b1;
        uop.rs2_used = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: uop.op = core_pkg::OP_ADD;
          {7'b0100000, 3'b000}: uop.op = core_pkg::OP_SUB;
          {7'b0000000, 3'b111}: uop.op = core_pkg::OP_AND;
          {7'b0000000, 3'b110}: uop.op = core_pkg::OP_OR;
          {7'b0000000, 3'b100}: uop.op = core_pkg::OP_XOR;
          {7'b0000000, 3'b001}: uop.op = core_pkg::OP_SLL;
          {7'b0000000, 3'b101}: uop.op = core_pkg::OP_SRL;
          {7'b0000000, 3'b010}: uop.op = core_pkg::OP_SLT;
          default: begin
            uop.rs1_used = 1'b0;
            uop.rs2_used = 1'b0;
          end
        endcase
      end
      // only ADDI out of the OP-IMM group
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          uop.op       = core_pkg::OP_ADDI;
          uop.rs1_used = 1'b1;
          uop.imm      = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
        end
      end
      7'b0110111: begin
        uop.op  = core_pkg::OP_LUI;
        uop.imm = {inst[31:12], 12'b0};
      end
      default: ;
    endcase

    uop.rs1      = uop.rs1_used ? inst[19:15] : '0;
    uop.rs2      = uop.rs2_used ? inst[24:20] : '0;
    uop.rd       = (uop.op != core_pkg::OP_NOP) ? inst[11:7] : '0;
    uop.rd_write = (uop.op != core_pkg::OP_NOP) && (uop.rd != '0);
  end

endmodule

// File: inst_fetch.sv
// one 32-bit word per cycle, no branches, so the PC only steps by 4
// icache_data must belong to icache_addr whenever icache_data_valid is high
// a word is taken only when the buffer has room

`timescale 1ns/1ps

`include "core_consts.svh"

module inst_fetch (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [`CORE_XLEN-1:0] icache_data,
  input  logic                  icache_data_valid,
  input  logic                  full,
  output logic [`CORE_XLEN-1:0] icache_addr,
  output logic                  push,
  output core_pkg::micro_op_t   push_uop
);

  logic [`CORE_XLEN-1:0] pc;

  // the PC doubles as the icache address
  assign icache_addr = pc;

  // accept when the word is there and the buffer can take it
  assign push = icache_data_valid && !full;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= `CORE_RESET_PC;
    end else if (push) begin
      pc <= pc + `CORE_XLEN'd4;
    end
  end

  // decode in the same cycle as the accept
  inst_decode decode_i (
    .inst (icache_data),
    .pc   (pc),
    .uop  (push_uop)
  );

endmodule

// File: fetch_buffer.sv
// show-ahead micro-op FIFO, depth must be a power of two of 2 or more
// push must only come with full low and pop with empty low, neither is rechecked

`timescale 1ns/1ps

`include "core_consts.svh"

module fetch_buffer #(
  parameter int depth = `CORE_FB_DEPTH
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                push,
  input  core_pkg::micro_op_t push_uop,
  input  logic                pop,
  output core_pkg::micro_op_t head_uop,
  output logic                empty,
  output logic                full
);

  localparam int ptr_width = $clog2(depth);

  core_pkg::micro_op_t entries [depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;

  assign head_uop = entries[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == (ptr_width + 1)'(depth));

  always_ff @(posedge clock) begin
    if (push) begin
      entries[wr_ptr] <= push_uop;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: int_exec.sv
// in-order issue from the buffer head, guarded by one busy bit per register
// pop edge -> stage 1 (operands), next edge -> stage 2 (result), retire from stage 2
// no bypass: a dependent op pops the cycle after its producer writes back

`timescale 1ns/1ps

`include "core_consts.svh"

module int_exec (
  input  logic                            clock,
  input  logic                            reset,
  input  core_pkg::micro_op_t             head_uop,
  input  logic                            empty,
  output logic                            pop,
  output logic                            retire_valid,
  output logic [`CORE_XLEN-1:0]           retire_pc,
  output logic                            retire_rd_write,
  output logic [`CORE_REG_INDEX_SIZE-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]           retire_data
);

  logic [`CORE_XLEN-1:0]     regs [`CORE_NUM_REGS];
  logic [`CORE_NUM_REGS-1:0] busy;

  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;

  logic                  s1_valid;
  core_pkg::micro_op_t   s1_uop;
  logic [`CORE_XLEN-1:0] s1_rs1_data;
  logic [`CORE_XLEN-1:0] s1_rs2_data;
  logic [`CORE_XLEN-1:0] alu_result;

  logic                            s2_valid;
  logic [`CORE_XLEN-1:0]           s2_pc;
  logic                            s2_rd_write;
  logic [`CORE_REG_INDEX_SIZE-1:0] s2_rd;
  logic [`CORE_XLEN-1:0]           s2_result;
  logic                            s2_clear_busy;

  // issue only when every used source is settled
  assign pop = !empty &&
               !(head_uop.rs1_used && busy[head_uop.rs1]) &&
               !(head_uop.rs2_used && busy[head_uop.rs2]);

  // x0 is never written, so its entry is not trusted
  assign rs1_data = (head_uop.rs1 == '0) ? '0 : regs[head_uop.rs1];
  assign rs2_data = (head_uop.rs2 == '0) ? '0 : regs[head_uop.rs2];

  always_ff @(posedge clock) begin
    s1_uop      <= head_uop;
    s1_rs1_data <= rs1_data;
    s1_rs2_data <= rs2_data;
    s2_pc       <= s1_uop.pc;
    s2_rd       <= s1_uop.rd;
    s2_rd_write <= s1_uop.rd_write;
    s2_result   <= s1_uop.rd_write ? alu_result : '0;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= pop;
      s2_valid <= s1_valid;
    end
  end

  always_comb begin
    case (s1_uop.op)
      core_pkg::OP_ADD:  alu_result = s1_rs1_data + s1_rs2_data;
      core_pkg::OP_SUB:  alu_result = s1_rs1_data - s1_rs2_data;
      core_pkg::OP_AND:  alu_result = s1_rs1_data & s1_rs2_data;
      core_pkg::OP_OR:   alu_result = s1_rs1_data | s1_rs2_data;
      core_pkg::OP_XOR:  alu_result = s1_rs1_data ^ s1_rs2_data;
      core_pkg::OP_SLL:  alu_result = s1_rs1_data << s1_rs2_data[4:0];
      core_pkg::OP_SRL:  alu_result = s1_rs1_data >> s1_rs2_data[4:0];
      core_pkg::OP_SLT:  alu_result = {{(`CORE_XLEN-1){1'b0}},
                                       $signed(s1_rs1_data) < $signed(s1_rs2_data)};
      core_pkg::OP_ADDI: alu_result = s1_rs1_data + s1_uop.imm;
      core_pkg::OP_LUI:  alu_result = s1_uop.imm;
      default:           alu_result = '0;
    endcase
  end

  // write-back
  always_ff @(posedge clock) begin
    if (s2_valid && s2_rd_write && (s2_rd != '0)) begin
      regs[s2_rd] <= s2_result;
    end
  end

  // keep the bit when a younger op in stage 1 writes the same register
  assign s2_clear_busy = s2_valid && s2_rd_write &&
                         !(s1_valid && s1_uop.rd_write && (s1_uop.rd == s2_rd));

  // set after clear, so a new producer at the write-back edge wins
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (s2_clear_busy) begin
        busy[s2_rd] <= 1'b0;
      end
      if (pop && head_uop.rd_write) begin
        busy[head_uop.rd] <= 1'b1;
      end
    end
  end

  assign retire_valid    = s2_valid;
  assign retire_pc       = s2_pc;
  assign retire_rd_write = s2_rd_write;
  assign retire_rd       = s2_rd;
  assign retire_data     = s2_result;

endmodule

// File: core.sv
// single-issue RV32 integer subset, one fetch word per cycle, no branches
// retirement is in program order, at most one per cycle
// retire_data is zero whenever retire_rd_write is low

`timescale 1ns/1ps

`include "core_consts.svh"

module core (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [`CORE_XLEN-1:0]           icache_data,
  input  logic                            icache_data_valid,
  output logic [`CORE_XLEN-1:0]           icache_addr,
  output logic                            retire_valid,
  output logic [`CORE_XLEN-1:0]           retire_pc,
  output logic                            retire_rd_write,
  output logic [`CORE_REG_INDEX_SIZE-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]           retire_data
);

  logic                push;
  core_pkg::micro_op_t push_uop;
  logic                full;
  logic                pop;
  core_pkg::micro_op_t head_uop;
  logic                empty;

  inst_fetch fetch_i (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .full              (full),
    .icache_addr       (icache_addr),
    .push              (push),
    .push_uop          (push_uop)
  );

  fetch_buffer #(
    .depth (`CORE_FB_DEPTH)
  ) buffer_i (
    .clock    (clock),
    .reset    (reset),
    .push     (push),
    .push_uop (push_uop),
    .pop      (pop),
    .head_uop (head_uop),
    .empty    (empty),
    .full     (full)
  );

  int_exec exec_i (
    .clock           (clock),
    .reset           (reset),
    .head_uop        (head_uop),
    .empty           (empty),
    .pop             (pop),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_rd_write (retire_rd_write),
    .retire_rd       (retire_rd),
    .retire_data     (retire_data)
  );

endmodule

// File: core_tb_model.svh
// LFSR, random program generator and reference model, included inside core_tb
// RV32 opcode values are kept here apart from the RTL package
// model_regs[0] must be cleared by the includer and is never written

`ifndef CORE_TB_MODEL_SVH
`define CORE_TB_MODEL_SVH

localparam logic [6:0] rv_op_reg    = 7'b0110011;
localparam logic [6:0] rv_op_imm    = 7'b0010011;
localparam logic [6:0] rv_op_lui    = 7'b0110111;
localparam logic [6:0] rv_op_branch = 7'b1100011;

logic [31:0] lfsr_state = 32'h0a6b_8268;
logic [31:0] model_regs [32];

// fibonacci, taps 32 22 2 1, one step per bit
function automatic logic [31:0] lfsr_bits(input int count);
  logic [31:0] value;
  logic        feedback;
  value = '0;
  for (int i = 0; i < count; i++) begin
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    value      = {value[30:0], feedback};
  end
  return value;
endfunction

// mostly x0..x7 so that dependencies are frequent
function automatic logic [4:0] pick_reg();
  if (lfsr_bits(3) == 0) return 5'(lfsr_bits(5));
  return 5'(lfsr_bits(3));
endfunction

// addi x(index+1), x0, imm
function automatic logic [31:0] prologue_instruction(input int index);
  return {12'(lfsr_bits(12)), 5'd0, 3'b000, 5'(index + 1), rv_op_imm};
endfunction

function automatic logic [31:0] random_instruction();
  logic [3:0] kind;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;
  kind = 4'(lfsr_bits(4));
  f3   = 3'(lfsr_bits(3));
  f7   = 7'b0000000;
  rd   = pick_reg();
  rs1  = pick_reg();
  rs2  = pick_reg();
  // sltu is not supported, sub takes its slot
  if (f3 == 3'b011) begin
    f3 = 3'b000;
    f7 = 7'b0100000;
  end
  if (kind < 8) return {f7, rs2, rs1, f3, rd, rv_op_reg};
  if (kind < 11) return {12'(lfsr_bits(12)), rs1, 3'b000, rd, rv_op_imm};
  if (kind < 13) return {20'(lfsr_bits(20)), rd, rv_op_lui};
  // unsupported: other OP-IMM functions, branches, the multiply group
  if (kind == 13) begin
    return {12'(lfsr_bits(12)), rs1, ((f3 == 3'b000) ? 3'b010 : f3), rd, rv_op_imm};
  end
  if (kind == 14) return {7'(lfsr_bits(7)), rs2, rs1, 3'b000, 5'(lfsr_bits(5)), rv_op_branch};
  return {7'b0000001, rs2, rs1, f3, rd, rv_op_reg};
endfunction

// executes one instruction in program order on the model registers
task automatic model_retire(input logic [31:0] inst, output logic write,
                            output logic [4:0] rd, output logic [31:0] data);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  logic        known;
  a      = model_regs[inst[19:15]];
  b      = model_regs[inst[24:20]];
  known  = 1'b1;
  result = '0;
  case (inst[6:0])
    rv_op_reg: begin
      case ({inst[31:25], inst[14:12]})
        {7'b0000000, 3'b000}: result = a + b;
        {7'b0100000, 3'b000}: result = a - b;
        {7'b0000000, 3'b111}: result = a & b;
        {7'b0000000, 3'b110}: result = a | b;
        {7'b0000000, 3'b100}: result = a ^ b;
        {7'b0000000, 3'b001}: result = a << b[4:0];
        {7'b0000000, 3'b101}: result = a >> b[4:0];
        {7'b0000000, 3'b010}: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        default:              known = 1'b0;
      endcase
    end
    rv_op_imm: begin
      if (inst[14:12] == 3'b000) result = a + {{20{inst[31]}}, inst[31:20]};
      else known = 1'b0;
    end
    rv_op_lui: result = {inst[31:12], 12'b0};
    default:   known = 1'b0;
  endcase
  rd    = inst[11:7];
  write = known && (rd != 5'd0);
  data  = write ? result : 32'd0;
  if (write) model_regs[rd] = data;
endtask

`endif

// File: core_tb.sv
// self-checking testbench for core with a random 256-word program
// words 0..30 set x1..x31 so that no register is read before it is written
// the icache model gives words on LFSR-chosen cycles and nothing past the program

`timescale 1ns/1ps

`include "core_consts.svh"

module core_tb;

  localparam int num_insts       = 256;
  localparam int clock_period    = 4;
  localparam int reset_cycles    = 10;
  localparam int cycles_per_inst = 12;
  localparam int timeout_ns      = (num_insts * cycles_per_inst + reset_cycles) * clock_period;

  logic        clock = 1'b0;
  logic        reset;
  logic [31:0] icache_data;
  logic        icache_data_valid;
  logic [31:0] icache_addr;
  logic        retire_valid;
  logic [31:0] retire_pc;
  logic        retire_rd_write;
  logic [4:0]  retire_rd;
  logic [31:0] retire_data;

  logic [31:0] imem [num_insts];
  logic        was_reset;
  logic [31:0] prev_addr;
  logic        prev_valid;
  logic [31:0] exp_pc;
  logic        exp_write;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  int          retired;

  `include "core_tb_model.svh"

  core dut_i (
    .clock             (clock),
    .reset             (reset),
    .icache_data       (icache_data),
    .icache_data_valid (icache_data_valid),
    .icache_addr       (icache_addr),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_rd_write   (retire_rd_write),
    .retire_rd         (retire_rd),
    .retire_data       (retire_data)
  );

  always #(clock_period / 2) clock = ~clock;

  task automatic end_in_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what);
    $display("** Error at %0t ns: %s", $time, what);
    end_in_failure();
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    end_in_failure();
  endtask

  initial begin
    reset             = 1'b1;
    icache_data       = '0;
    icache_data_valid = 1'b0;
    exp_pc            = `CORE_RESET_PC;
    retired           = 0;
    for (int r = 0; r < 32; r++) model_regs[r] = '0;
    for (int i = 0; i < num_insts; i++) begin
      imem[i] = (i < 31) ? prologue_instruction(i) : random_instruction();
    end
    repeat (reset_cycles) @(posedge clock);
    #1;
    reset = 1'b0;
    wait (retired == num_insts);
    // a few idle cycles to catch a stray retirement
    repeat (4) @(posedge clock);
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    #(timeout_ns);
    report_failure($sformatf("retirement did not finish, %0d of %0d instructions retired",
                             retired, num_insts));
  end

  // reset is sampled at the edge and the icache inputs change 1 ns later
  always @(posedge clock) begin
    was_reset = reset;
    #1;
    if (was_reset || icache_addr >= 32'(num_insts * 4)) begin
      icache_data_valid = 1'b0;
      icache_data       = '0;
    end else begin
      icache_data       = imem[icache_addr[9:2]];
      icache_data_valid = (lfsr_bits(2) != 0);
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    if (was_reset) begin
      assert (!retire_valid) else report_mismatch("retire_valid is high in reset");
      assert (icache_addr == `CORE_RESET_PC)
        else report_mismatch($sformatf("icache_addr %h in reset", icache_addr));
    end else begin
      assert ((icache_addr == prev_addr) || (prev_valid && icache_addr == prev_addr + 32'd4))
        else report_mismatch($sformatf("icache_addr %h after %h, valid was %b",
                                       icache_addr, prev_addr, prev_valid));
    end
    prev_addr  = icache_addr;
    prev_valid = icache_data_valid;

    if (retire_valid && !was_reset) begin
      assert (retired < num_insts)
        else report_mismatch("retirement past the end of the program");
      assert (retire_pc == exp_pc)
        else report_mismatch($sformatf("retire_pc %h, expected %h", retire_pc, exp_pc));
      model_retire(imem[exp_pc[9:2]], exp_write, exp_rd, exp_data);
      assert (retire_rd_write == exp_write)
        else report_mismatch($sformatf("pc %h retire_rd_write %b, expected %b",
                                       exp_pc, retire_rd_write, exp_write));
      if (exp_write) begin
        assert (retire_rd == exp_rd)
          else report_mismatch($sformatf("pc %h retire_rd %0d, expected %0d",
                                         exp_pc, retire_rd, exp_rd));
      end
      assert (retire_data == exp_data)
        else report_mismatch($sformatf("pc %h retire_data %h, expected %h",
                                       exp_pc, retire_data, exp_data));
      exp_pc  = exp_pc + 32'd4;
      retired = retired + 1;
    end
  end

endmodule

// File: compile.f
+incdir+.
core_pkg.sv
inst_decode.sv
inst_fetch.sv
fetch_buffer.sv
int_exec.sv
core.sv
core_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = core_tb
FILELIST  = compile.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test completed successfully

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
